// File: rtl/trap_mon_cfg.svh
//////////////////////////////
// Trap monitor configuration
// Widths, exception cause codes, privilege encodings and the
// register map of the status port
//////////////////////////////

`ifndef TRAP_MON_CFG_SVH
`define TRAP_MON_CFG_SVH

// Datapath widths
`define TM_XLEN              32
`define TM_CAUSE_W           5

// Synchronous exception codes as written to mcause
`define TM_CAUSE_INSTR_FAULT 1
`define TM_CAUSE_ILLEGAL     2
`define TM_CAUSE_EBREAK      3
`define TM_CAUSE_ECALL_M     11
`define TM_CAUSE_INSTR_BUS   24

// Privilege level encodings
`define TM_PRIV_U            0
`define TM_PRIV_M            3

// Word addresses of the Wishbone register map
`define TM_ADR_W             3
`define TM_REG_ERR           0
`define TM_REG_FOUND         1
`define TM_REG_EPC_BASE      2

`endif

// File: rtl/core_obs_pkg.sv
//////////////////////////////
// Core observation types
// Everything the monitor sees of the core: PCs, cause codes,
// privilege levels and the probe buses
//////////////////////////////

`include "trap_mon_cfg.svh"

package core_obs_pkg;

  // A fetch PC, a WB PC or a value headed for mepc
  typedef logic [`TM_XLEN-1:0]    pc_t;
  typedef logic [`TM_CAUSE_W-1:0] cause_t;

  // Only user and machine mode exist on this core
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'(`TM_PRIV_U),
    PRIV_LVL_M = 2'(`TM_PRIV_M)
  } priv_lvl_e;

  // Instruction sitting in the writeback stage
  typedef struct packed {
    logic instr_valid;
    pc_t  pc;
    logic illegal;
    logic ecall;
    logic ebreak;
    logic bus_err;
    // High when the MPU status of the fetch is anything but OK
    logic mpu_err;
    logic mret;
  } wb_obs_t;

  // Controller FSM outputs and the CSR values it is about to write
  typedef struct packed {
    logic   irq_ack;
    logic   dbg_pending_allowed;
    logic   nmi_sel;
    logic   debug_mode;
    logic   debug_mode_next;
    logic   pc_set_exception;
    logic   csr_save_cause;
    logic   cause_irq;
    cause_t cause_code;
    pc_t    mepc_next;
  } ctrl_obs_t;

  // Privilege state along the pipeline
  typedef struct packed {
    priv_lvl_e priv_if;
    priv_lvl_e priv_if_q;
    priv_lvl_e priv_cur;
    priv_lvl_e mpp;
    logic      mret_id;
    logic      mret_ex;
    logic      mret_wb;
    logic      id_valid;
  } priv_obs_t;

endpackage

// File: rtl/trap_mon_pkg.sv
//////////////////////////////
// Trap monitor types
// Exception classes, flag vectors and the Wishbone port
//////////////////////////////

`include "trap_mon_cfg.svh"

package trap_mon_pkg;

  // Numbering matches the bit position in the found and error vectors
  typedef enum logic [2:0] {
    EXC_ILLEGAL   = 3'd0,
    EXC_ECALL     = 3'd1,
    EXC_EBREAK    = 3'd2,
    EXC_INSTR_BUS = 3'd3,
    EXC_INSTR_MPU = 3'd4
  } exc_class_e;

  typedef logic [4:0] class_vec_t;

  // [4:0] mepc mismatch per class, [5] step retire,
  // [8:6] privilege checks, [9] reserved
  typedef logic [9:0] err_vec_t;

  typedef logic [`TM_ADR_W-1:0] wb_adr_t;
  typedef logic [`TM_XLEN-1:0]  wb_data_t;

  // Master side of a Wishbone classic cycle
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_adr_t  adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

  typedef enum logic {
    REG_IDLE,
    REG_ACK
  } reg_state_e;

endpackage

// File: rtl/trap_mepc_checker.sv
//////////////////////////////
// mepc checker
// Records the PC of the first instruction of each exception
// class in WB and the first mepc saved for that class, then
// flags a mismatch once both are known
//////////////////////////////

`timescale 1ns/100ps

`include "trap_mon_cfg.svh"

module trap_mepc_checker (
  input  logic                         clk,
  input  logic                         rst_ni,
  input  core_obs_pkg::wb_obs_t        wb_obs_i,
  input  core_obs_pkg::ctrl_obs_t      ctrl_obs_i,
  output trap_mon_pkg::class_vec_t     found_o,
  output core_obs_pkg::pc_t [4:0]      exp_pc_o,
  output trap_mon_pkg::class_vec_t     mismatch_o
);
  import core_obs_pkg::*;
  import trap_mon_pkg::*;

  // mcause code of each class, indexed by exc_class_e
  localparam cause_t [4:0] CLASS_CAUSE = {
    cause_t'(`TM_CAUSE_INSTR_FAULT),
    cause_t'(`TM_CAUSE_INSTR_BUS),
    cause_t'(`TM_CAUSE_EBREAK),
    cause_t'(`TM_CAUSE_ECALL_M),
    cause_t'(`TM_CAUSE_ILLEGAL)
  };

  logic       wb_ok;
  logic       no_dbg;
  class_vec_t exp_hit;
  class_vec_t act_hit;
  class_vec_t exp_found_q;
  class_vec_t act_found_q;
  class_vec_t done_q;
  class_vec_t pc_diff;
  class_vec_t mismatch_q;
  pc_t [4:0]  exp_pc_q;
  pc_t [4:0]  act_pc_q;

  // WB instruction is a real trap candidate, not overtaken by an
  // interrupt, a debug request or an NMI
  assign wb_ok  = wb_obs_i.instr_valid && !ctrl_obs_i.irq_ack &&
                  !ctrl_obs_i.dbg_pending_allowed && !ctrl_obs_i.nmi_sel;
  assign no_dbg = !ctrl_obs_i.debug_mode_next;

  // Priority is MPU fault, bus fault, illegal, ECALL, EBREAK
  always_comb begin
    exp_hit = '0;
    exp_hit[EXC_INSTR_MPU] = wb_ok && no_dbg && wb_obs_i.mpu_err;
    exp_hit[EXC_INSTR_BUS] = wb_ok && no_dbg && wb_obs_i.bus_err && !wb_obs_i.mpu_err;
    exp_hit[EXC_ILLEGAL]   = wb_ok && no_dbg && wb_obs_i.illegal &&
                             !(wb_obs_i.bus_err || wb_obs_i.mpu_err);
    exp_hit[EXC_ECALL]     = wb_ok && no_dbg && wb_obs_i.ecall &&
                             !(wb_obs_i.bus_err || wb_obs_i.mpu_err || wb_obs_i.illegal);
    // EBREAK is still expected to trap while debug mode is pending
    exp_hit[EXC_EBREAK]    = wb_ok && wb_obs_i.ebreak &&
                             !(wb_obs_i.bus_err || wb_obs_i.mpu_err ||
                               wb_obs_i.illegal || wb_obs_i.ecall);
  end

  // Interrupt cause saves are ignored on the actual side
  always_comb begin
    for (int c = 0; c < 5; c++) begin
      act_hit[c] = ctrl_obs_i.csr_save_cause && !ctrl_obs_i.cause_irq &&
                   (ctrl_obs_i.cause_code == CLASS_CAUSE[c]);
      pc_diff[c] = exp_pc_q[c] != act_pc_q[c];
    end
  end

  // Only the first occurrence of each class is kept
  always_ff @(posedge clk) begin
    for (int c = 0; c < 5; c++) begin
      if (exp_hit[c] && !exp_found_q[c]) begin
        exp_pc_q[c] <= wb_obs_i.pc;
      end
      if (act_hit[c] && !act_found_q[c]) begin
        act_pc_q[c] <= ctrl_obs_i.mepc_next;
      end
    end
  end

  // The compare fires once, on the edge after both sides are found
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_found_q <= '0;
      act_found_q <= '0;
      done_q      <= '0;
      mismatch_q  <= '0;
    end else begin
      exp_found_q <= exp_found_q | exp_hit;
      act_found_q <= act_found_q | act_hit;
      done_q      <= exp_found_q & act_found_q;
      mismatch_q  <= exp_found_q & act_found_q & ~done_q & pc_diff;
    end
  end

  assign found_o    = exp_found_q;
  assign exp_pc_o   = exp_pc_q;
  assign mismatch_o = mismatch_q;

endmodule

// File: rtl/step_retire_checker.sv
//////////////////////////////
// Single-step retire checker
// Flags a second retirement while single stepping before the
// core has gone back into debug mode
//////////////////////////////

`timescale 1ns/100ps

module step_retire_checker (
  input  logic clk,
  input  logic rst_ni,
  input  logic wb_valid_i,
  input  logic dcsr_step_i,
  input  logic debug_mode_i,
  output logic step_err_o
);

  logic armed_q;
  logic step_err_q;
  logic step_err_d;

  // A retirement is fine once the core sits in debug mode with step set,
  // anything else after the first stepped instruction is a violation
  assign step_err_d = wb_valid_i && armed_q && !(debug_mode_i && dcsr_step_i);

  // Armed by a stepped retirement, disarmed by entry into debug mode
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q <= 1'b0;
    end else if (debug_mode_i) begin
      armed_q <= 1'b0;
    end else if (wb_valid_i && dcsr_step_i) begin
      armed_q <= 1'b1;
    end
  end

  // Flag comes one cycle after the offending retirement
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      step_err_q <= 1'b0;
    end else begin
      step_err_q <= step_err_d;
    end
  end

  assign step_err_o = step_err_q;

endmodule

// File: rtl/priv_lvl_checker.sv
//////////////////////////////
// Privilege level checker
// Consistency of the IF privilege with the current privilege,
// entry into user mode and trapping into machine mode
//////////////////////////////

`timescale 1ns/100ps

module priv_lvl_checker (
  input  logic                    clk,
  input  logic                    rst_ni,
  input  core_obs_pkg::priv_obs_t priv_obs_i,
  input  logic                    debug_mode_i,
  input  logic                    pc_set_exception_i,
  output logic [2:0]              priv_err_o
);
  import core_obs_pkg::*;

  priv_lvl_e  priv_if_prev_q;
  logic       mret_in_pipe;
  logic       mret_to_user;
  logic [2:0] err_d;
  logic [2:0] err_q;

  // An MRET in ID already moves the IF privilege while the current
  // privilege only follows when it retires
  assign mret_in_pipe = priv_obs_i.mret_id || priv_obs_i.mret_ex || priv_obs_i.mret_wb;
  assign mret_to_user = priv_obs_i.mret_id && priv_obs_i.id_valid &&
                        (priv_obs_i.mpp == PRIV_LVL_U);

  always_comb begin
    err_d[0] = (priv_obs_i.priv_if_q != priv_obs_i.priv_cur) && !mret_in_pipe;
    // Dropping to user mode needs an MRET with mpp set to user
    err_d[1] = (priv_obs_i.priv_if != priv_if_prev_q) &&
               (priv_obs_i.priv_if == PRIV_LVL_U) && !mret_to_user;
    // Exceptions outside debug mode must fetch the handler in machine mode
    err_d[2] = pc_set_exception_i && !debug_mode_i && (priv_obs_i.priv_if != PRIV_LVL_M);
  end

  // The core leaves reset in machine mode
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      priv_if_prev_q <= PRIV_LVL_M;
      err_q          <= '0;
    end else begin
      priv_if_prev_q <= priv_obs_i.priv_if;
      err_q          <= err_d;
    end
  end

  assign priv_err_o = err_q;

endmodule

// File: rtl/wb_status_regs.sv
//////////////////////////////
// Status register slave
// Wishbone classic port with the sticky error register, the
// found vector and the expected mepc of each class
//////////////////////////////

`timescale 1ns/100ps

`include "trap_mon_cfg.svh"

module wb_status_regs (
  input  logic                     clk,
  input  logic                     rst_ni,
  input  trap_mon_pkg::wb_req_t    wb_req_i,
  output trap_mon_pkg::wb_rsp_t    wb_rsp_o,
  input  trap_mon_pkg::err_vec_t   flags_i,
  input  trap_mon_pkg::class_vec_t found_i,
  input  core_obs_pkg::pc_t [4:0]  exp_pc_i,
  output logic                     err_o
);
  import trap_mon_pkg::*;

  reg_state_e state_q;
  logic       ack_q;
  logic       access;
  wb_data_t   rd_data;
  wb_data_t   rd_data_q;
  wb_adr_t    epc_idx;
  err_vec_t   err_q;
  err_vec_t   err_clr;
  err_vec_t   err_d;

  // A new cycle is only taken from idle
  assign access  = (state_q == REG_IDLE) && wb_req_i.cyc && wb_req_i.stb;
  assign epc_idx = wb_req_i.adr - wb_adr_t'(`TM_REG_EPC_BASE);

  // Read mux, a PC of a class not yet found reads as zero
  always_comb begin
    rd_data = '0;
    if (wb_req_i.adr == wb_adr_t'(`TM_REG_ERR)) begin
      rd_data = wb_data_t'(err_q);
    end else if (wb_req_i.adr == wb_adr_t'(`TM_REG_FOUND)) begin
      rd_data = wb_data_t'(found_i);
    end else if ((wb_req_i.adr >= wb_adr_t'(`TM_REG_EPC_BASE)) && (epc_idx < 3'd5)) begin
      if (found_i[epc_idx]) begin
        rd_data = exp_pc_i[epc_idx];
      end
    end
  end

  //////////////////////////////
  // Sticky error register
  //////////////////////////////

  // Write one to clear, a flag raised in the same cycle wins
  assign err_clr = (access && wb_req_i.we && (wb_req_i.adr == wb_adr_t'(`TM_REG_ERR))) ?
                   wb_req_i.dat[9:0] : '0;

  always_comb begin
    err_d    = (err_q & ~err_clr) | flags_i;
    err_d[9] = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= '0;
    end else begin
      err_q <= err_d;
    end
  end

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // Ack for one cycle, then hold off until the master drops stb
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= REG_IDLE;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= access;
      if (access) begin
        state_q <= REG_ACK;
      end else if ((state_q == REG_ACK) && !wb_req_i.stb) begin
        state_q <= REG_IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rd_data_q <= rd_data;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rd_data_q;
  assign err_o        = |err_q;

endmodule

// File: rtl/trap_monitor.sv
//////////////////////////////
// Trap and privilege monitor
// Runs the mepc, single-step and privilege checks beside the
// core and reports them through a Wishbone status port
//////////////////////////////

`timescale 1ns/100ps

module trap_monitor (
  input  logic                    clk,
  input  logic                    rst_ni,
  input  core_obs_pkg::wb_obs_t   wb_obs_i,
  input  core_obs_pkg::ctrl_obs_t ctrl_obs_i,
  input  core_obs_pkg::priv_obs_t priv_obs_i,
  input  logic                    dcsr_step_i,
  input  logic                    wb_valid_i,
  input  trap_mon_pkg::wb_req_t   wb_req_i,
  output trap_mon_pkg::wb_rsp_t   wb_rsp_o,
  output logic                    err_o
);
  import core_obs_pkg::*;
  import trap_mon_pkg::*;

  class_vec_t found;
  class_vec_t mismatch;
  pc_t [4:0]  exp_pc;
  logic       step_err;
  logic [2:0] priv_err;
  err_vec_t   flags;

  trap_mepc_checker u_mepc (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .wb_obs_i   (wb_obs_i),
    .ctrl_obs_i (ctrl_obs_i),
    .found_o    (found),
    .exp_pc_o   (exp_pc),
    .mismatch_o (mismatch)
  );

  step_retire_checker u_step (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .wb_valid_i   (wb_valid_i),
    .dcsr_step_i  (dcsr_step_i),
    .debug_mode_i (ctrl_obs_i.debug_mode),
    .step_err_o   (step_err)
  );

  priv_lvl_checker u_priv (
    .clk                (clk),
    .rst_ni             (rst_ni),
    .priv_obs_i         (priv_obs_i),
    .debug_mode_i       (ctrl_obs_i.debug_mode),
    .pc_set_exception_i (ctrl_obs_i.pc_set_exception),
    .priv_err_o         (priv_err)
  );

  // Reserved bit on top, then privilege, step and per-class mepc flags
  assign flags = {1'b0, priv_err, step_err, mismatch};

  wb_status_regs u_regs (
    .clk      (clk),
    .rst_ni   (rst_ni),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .flags_i  (flags),
    .found_i  (found),
    .exp_pc_i (exp_pc),
    .err_o    (err_o)
  );

endmodule

// File: dv/tb_trap_monitor.sv
//////////////////////////////
// Trap monitor testbench
// Directed tests of the mepc, single-step and privilege checks,
// with results read back over the Wishbone status port
//////////////////////////////

`timescale 1ns/100ps

`include "trap_mon_cfg.svh"

module tb_trap_monitor;
  import core_obs_pkg::*;
  import trap_mon_pkg::*;

  // All tests together take well under 200 cycles, the limit is ten times that
  localparam int TEST_CYCLES = 200;
  localparam int CYCLE_LIMIT = 10 * TEST_CYCLES;
  localparam int ACK_LIMIT   = 8;

  // Bit positions in the found and error registers
  localparam int CLS_ILLEGAL    = 0;
  localparam int CLS_ECALL      = 1;
  localparam int CLS_BUS        = 3;
  localparam int CLS_MPU        = 4;
  localparam int BIT_STEP       = 5;
  localparam int BIT_PRIV_ENTRY = 7;
  localparam int BIT_PRIV_TRAP  = 8;

  logic        clk;
  logic        rst_ni;
  wb_obs_t     wb_obs;
  ctrl_obs_t   ctrl_obs;
  priv_obs_t   priv_obs;
  logic        dcsr_step;
  logic        wb_valid;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        err;

  integer      seed;
  int          errors;
  int          tests;
  int          failed_tests;
  int          cycles;
  logic [31:0] found_exp;

  trap_monitor UUT (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .wb_obs_i    (wb_obs),
    .ctrl_obs_i  (ctrl_obs),
    .priv_obs_i  (priv_obs),
    .dcsr_step_i (dcsr_step),
    .wb_valid_i  (wb_valid),
    .wb_req_i    (wb_req),
    .wb_rsp_o    (wb_rsp),
    .err_o       (err)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Watchdog, ends the run if the tests never get to the summary
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles before the tests were done", cycles);
    $display("*** FAILED ***");
    $finish;
  end

  //////////////////////////////
  // Bus and probe drivers
  //////////////////////////////

  // Inputs always change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  // One Wishbone classic cycle, held until ack or until the wait runs out
  task automatic wb_access(input logic write, input int addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int waited;
    waited     = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = write;
    wb_req.adr = wb_adr_t'(addr);
    wb_req.dat = wdata;
    do begin
      next_cycle();
      waited++;
    end while (!wb_rsp.ack && (waited < ACK_LIMIT));
    if (!wb_rsp.ack) begin
      $display("Wishbone access to address %0d got no ack within %0d cycles", addr, ACK_LIMIT);
      errors++;
    end
    rdata  = wb_rsp.dat;
    wb_req = '0;
    // The slave needs one cycle with stb low before the next access
    next_cycle();
  endtask

  task automatic read_expect(input int addr, input logic [31:0] exp, input string name);
    logic [31:0] data;
    wb_access(1'b0, addr, 32'h0, data);
    if (data !== exp) begin
      $display("ERROR %s: read 0x%08h, expected 0x%08h", name, data, exp);
      errors++;
    end
  endtask

  task automatic clear_errors(input logic [31:0] mask);
    logic [31:0] data;
    wb_access(1'b1, `TM_REG_ERR, mask, data);
  endtask

  task automatic expect_err_o(input logic exp);
    if (err !== exp) begin
      $display("ERROR err_o: 0x%0h, expected 0x%0h", err, exp);
      errors++;
    end
  endtask

  // One instruction in WB for a single cycle
  task automatic wb_exception(input pc_t pc, input logic ill, input logic ecall,
                              input logic bus, input logic mpu);
    wb_obs.instr_valid = 1'b1;
    wb_obs.pc          = pc;
    wb_obs.illegal     = ill;
    wb_obs.ecall       = ecall;
    wb_obs.bus_err     = bus;
    wb_obs.mpu_err     = mpu;
    next_cycle();
    wb_obs = '0;
  endtask

  task automatic save_cause(input int code, input pc_t mepc);
    ctrl_obs.csr_save_cause = 1'b1;
    ctrl_obs.cause_code     = cause_t'(code);
    ctrl_obs.mepc_next      = mepc;
    next_cycle();
    ctrl_obs.csr_save_cause = 1'b0;
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests++;
    if (errors == start_errors) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: failed with %0d errors", name, errors - start_errors);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset_values();
    int start;
    start = errors;
    read_expect(`TM_REG_ERR, 32'h0, "err_reg");
    read_expect(`TM_REG_FOUND, 32'h0, "found_reg");
    expect_err_o(1'b0);
    report_test("reset_values", start);
  endtask

  // Matching mepc for an illegal instruction and for an ECALL
  task automatic test_clean_traps();
    int  start;
    pc_t pc_ill;
    pc_t pc_ecall;
    start = errors;
    pc_ill = $random(seed);
    pc_ill[1:0] = 2'b00;
    wb_exception(pc_ill, 1'b1, 1'b0, 1'b0, 1'b0);
    save_cause(`TM_CAUSE_ILLEGAL, pc_ill);
    idle_cycles(3);
    found_exp[CLS_ILLEGAL] = 1'b1;
    read_expect(`TM_REG_FOUND, found_exp, "found_reg");
    read_expect(`TM_REG_EPC_BASE + CLS_ILLEGAL, pc_ill, "epc_reg[0]");
    read_expect(`TM_REG_ERR, 32'h0, "err_reg");
    pc_ecall = $random(seed);
    pc_ecall[1:0] = 2'b00;
    if (pc_ecall == pc_ill) begin
      pc_ecall = pc_ill + 32'd4;
    end
    wb_exception(pc_ecall, 1'b0, 1'b1, 1'b0, 1'b0);
    save_cause(`TM_CAUSE_ECALL_M, pc_ecall);
    idle_cycles(3);
    found_exp[CLS_ECALL] = 1'b1;
    read_expect(`TM_REG_FOUND, found_exp, "found_reg");
    read_expect(`TM_REG_EPC_BASE + CLS_ECALL, pc_ecall, "epc_reg[1]");
    read_expect(`TM_REG_ERR, 32'h0, "err_reg");
    expect_err_o(1'b0);
    report_test("clean_traps", start);
  endtask

  // Bus fault whose saved mepc points at the next instruction
  task automatic test_bus_mismatch();
    int  start;
    pc_t pc_bus;
    start = errors;
    pc_bus = $random(seed);
    pc_bus[1:0] = 2'b00;
    wb_exception(pc_bus, 1'b0, 1'b0, 1'b1, 1'b0);
    save_cause(`TM_CAUSE_INSTR_BUS, pc_bus + 32'd4);
    idle_cycles(3);
    found_exp[CLS_BUS] = 1'b1;
    read_expect(`TM_REG_FOUND, found_exp, "found_reg");
    read_expect(`TM_REG_EPC_BASE + CLS_BUS, pc_bus, "epc_reg[3]");
    read_expect(`TM_REG_ERR, 32'h1 << CLS_BUS, "err_reg");
    expect_err_o(1'b1);
    clear_errors(32'h1 << CLS_BUS);
    read_expect(`TM_REG_ERR, 32'h0, "err_reg");
    expect_err_o(1'b0);
    report_test("bus_mismatch", start);
  endtask

  // MPU fault outranks the illegal flag on the same instruction
  task automatic test_mpu_priority();
    int  start;
    pc_t pc_mpu;
    start = errors;
    pc_mpu = $random(seed);
    pc_mpu[1:0] = 2'b00;
    wb_exception(pc_mpu, 1'b1, 1'b0, 1'b0, 1'b1);
    idle_cycles(2);
    found_exp[CLS_MPU] = 1'b1;
    read_expect(`TM_REG_FOUND, found_exp, "found_reg");
    read_expect(`TM_REG_EPC_BASE + CLS_MPU, pc_mpu, "epc_reg[4]");
    // No illegal instruction has been seen yet, so class 0 reads zero
    read_expect(`TM_REG_EPC_BASE + CLS_ILLEGAL, 32'h0, "epc_reg[0]");
    read_expect(`TM_REG_ERR, 32'h0, "err_reg");
    report_test("mpu_priority", start);
  endtask

  task automatic test_single_step();
    int start;
    start = errors;
    // Two stepped retirements with no debug entry in between
    dcsr_step = 1'b1;
    wb_valid  = 1'b1;
    next_cycle();
    wb_valid = 1'b0;
    next_cycle();
    wb_valid = 1'b1;
    next_cycle();
    wb_valid = 1'b0;
    idle_cycles(3);
    read_expect(`TM_REG_ERR, 32'h1 << BIT_STEP, "err_reg");
    expect_err_o(1'b1);
    clear_errors(32'h1 << BIT_STEP);
    // Entry into debug mode disarms the check before the next pair
    ctrl_obs.debug_mode = 1'b1;
    next_cycle();
    ctrl_obs.debug_mode = 1'b0;
    // Same pair, this time with a visit to debug mode between them
    wb_valid = 1'b1;
    next_cycle();
    wb_valid            = 1'b0;
    ctrl_obs.debug_mode = 1'b1;
    next_cycle();
    ctrl_obs.debug_mode = 1'b0;
    wb_valid            = 1'b1;
    next_cycle();
    wb_valid            = 1'b0;
    ctrl_obs.debug_mode = 1'b1;
    next_cycle();
    ctrl_obs.debug_mode = 1'b0;
    dcsr_step           = 1'b0;
    idle_cycles(3);
    read_expect(`TM_REG_ERR, 32'h0, "err_reg");
    expect_err_o(1'b0);
    report_test("single_step", start);
  endtask

  task automatic test_priv_checks();
    int start;
    start = errors;
    // IF drops to user mode with no MRET anywhere
    priv_obs.priv_if = PRIV_LVL_U;
    next_cycle();
    priv_obs.priv_if = PRIV_LVL_M;
    idle_cycles(3);
    read_expect(`TM_REG_ERR, 32'h1 << BIT_PRIV_ENTRY, "err_reg");
    expect_err_o(1'b1);
    clear_errors(32'h1 << BIT_PRIV_ENTRY);
    // Legal entry to user mode by MRET, then an exception fetched in user mode
    priv_obs.priv_if  = PRIV_LVL_U;
    priv_obs.mret_id  = 1'b1;
    priv_obs.id_valid = 1'b1;
    priv_obs.mpp      = PRIV_LVL_U;
    next_cycle();
    priv_obs.mret_id           = 1'b0;
    priv_obs.id_valid          = 1'b0;
    priv_obs.mpp               = PRIV_LVL_M;
    ctrl_obs.pc_set_exception  = 1'b1;
    next_cycle();
    ctrl_obs.pc_set_exception = 1'b0;
    priv_obs.priv_if          = PRIV_LVL_M;
    idle_cycles(3);
    read_expect(`TM_REG_ERR, 32'h1 << BIT_PRIV_TRAP, "err_reg");
    expect_err_o(1'b1);
    clear_errors(32'h1 << BIT_PRIV_TRAP);
    read_expect(`TM_REG_ERR, 32'h0, "err_reg");
    report_test("priv_checks", start);
  endtask

  initial begin
    seed         = 25;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    found_exp    = '0;
    rst_ni       = 1'b0;
    wb_obs       = '0;
    ctrl_obs     = '0;
    priv_obs     = '0;
    // Core comes out of reset in machine mode
    priv_obs.priv_if   = PRIV_LVL_M;
    priv_obs.priv_if_q = PRIV_LVL_M;
    priv_obs.priv_cur  = PRIV_LVL_M;
    priv_obs.mpp       = PRIV_LVL_M;
    dcsr_step          = 1'b0;
    wb_valid           = 1'b0;
    wb_req             = '0;
    repeat (8) @(posedge clk);
    #2;
    rst_ni = 1'b1;
    next_cycle();
    test_reset_values();
    test_mpu_priority();
    test_clean_traps();
    test_bus_mismatch();
    test_single_step();
    test_priv_checks();
    $display("Summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+rtl
rtl/core_obs_pkg.sv
rtl/trap_mon_pkg.sv
rtl/trap_mepc_checker.sv
rtl/step_retire_checker.sv
rtl/priv_lvl_checker.sv
rtl/wb_status_regs.sv
rtl/trap_monitor.sv
dv/tb_trap_monitor.sv

// File: Bender.yml
package:
  name: trap_monitor

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_obs_pkg.sv
      - rtl/trap_mon_pkg.sv
      - rtl/trap_mepc_checker.sv
      - rtl/step_retire_checker.sv
      - rtl/priv_lvl_checker.sv
      - rtl/wb_status_regs.sv
      - rtl/trap_monitor.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - dv/tb_trap_monitor.sv
